// File: common/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

	////////////////////
	// 640x480 at 60 Hz geometry
	////////////////////

	// Horizontal sections, in pixel clocks
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_pulse  = 96;
	localparam int h_back   = 48;
	localparam int h_total  = h_active + h_front + h_pulse + h_back;

	// Vertical sections, in lines
	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_pulse  = 2;
	localparam int v_back   = 33;
	localparam int v_total  = v_active + v_front + v_pulse + v_back;

	// Scan coordinate, wide enough for 799
	typedef logic [9:0] coord_t;

	// Porch/sync section of one axis
	typedef enum logic [1:0] {
		st_active,
		st_front,
		st_pulse,
		st_back
	} section_t;

	// Position on screen plus visible flag
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
	} scan_pos_t;

	// Color as rrr_ggg_bb
	typedef logic [7:0] pixel_t;

	// What leaves the chip for the DAC
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       blank_n;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} vga_out_t;

	////////////////////
	// Picture content
	////////////////////

	// Quadrant fills
	localparam pixel_t color_top_left     = 8'b111_000_00;
	localparam pixel_t color_bottom_left  = 8'b000_111_00;
	localparam pixel_t color_top_right    = 8'b000_000_11;
	localparam pixel_t color_bottom_right = 8'b111_111_00;
	localparam pixel_t color_white        = 8'b111_111_11;

	// Outline rectangle
	localparam coord_t border_x0 = 10'd100;
	localparam coord_t border_x1 = 10'd540;
	localparam coord_t border_y0 = 10'd100;
	localparam coord_t border_y1 = 10'd380;

endpackage

`default_nettype wire

// File: common/fb_bus_pkg.sv
`default_nettype none

package fb_bus_pkg;

	import video_timing_pkg::*;

	// One byte per visible pixel
	localparam int fb_depth = 307200;

	// Linear address, y * 640 + x
	typedef logic [18:0] fb_addr_t;

	////////////////////
	// Wishbone classic, write only
	////////////////////

	// Master to slave
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		fb_addr_t adr;
		pixel_t   dat;
	} wb_req_t;

	// Slave to master
	// Only ack, nothing is ever read back
	typedef struct packed {
		logic ack;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: hw/checker_writer.sv
`timescale 1ns/1ps
`default_nettype none

module checker_writer
	import video_timing_pkg::*, fb_bus_pkg::*;
(
	input  logic    M10k_pll,
	input  logic    reset,
	output wb_req_t wb_req,
	input  wb_rsp_t wb_rsp
);

	// Sweep position of the pixel being written
	coord_t x;
	coord_t y;
	// Bus cycle open, stays up once out of reset
	logic   cyc;
	// Fill for the current position
	pixel_t color;

	// Quadrant select
	always_comb begin
		if (x < coord_t'(h_active / 2)) begin
			color = (y < coord_t'(v_active / 2)) ? color_top_left : color_bottom_left;
		end else begin
			color = (y < coord_t'(v_active / 2)) ? color_top_right : color_bottom_right;
		end
	end

	////////////////////
	// Bus drive
	////////////////////

	// Address and data only move on ack, so they stay steady while waiting
	assign wb_req.cyc = cyc;
	assign wb_req.we  = cyc;
	assign wb_req.adr = fb_addr_t'(y) * fb_addr_t'(h_active) + fb_addr_t'(x);
	assign wb_req.dat = color;
	// Strobe drops in the ack cycle
	// This is the one idle cycle between writes, two cycles per pixel
	// A late ack just leaves the strobe up
	assign wb_req.stb = cyc & ~wb_rsp.ack;

	////////////////////
	// Sweep counters
	////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			cyc <= 1'b0;
			x   <= '0;
			y   <= '0;
		end else begin
			cyc <= 1'b1;
			// Step to next pixel once the write is taken
			if (cyc && wb_rsp.ack) begin
				if (x == coord_t'(h_active - 1)) begin
					x <= '0;
					// End of frame wraps back to the top
					y <= (y == coord_t'(v_active - 1)) ? '0 : y + 1'b1;
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/frame_buffer/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
	import video_timing_pkg::*, fb_bus_pkg::*;
(
	input  logic      M10k_pll,
	input  logic      reset,
	input  wb_req_t   wb_req,
	output wb_rsp_t   wb_rsp,
	input  scan_pos_t scan,
	output pixel_t    pixel
);

	// On-chip pixel store, maps onto block RAM
	pixel_t   mem [fb_depth];
	// Write accepted this cycle
	logic     wr_hit;
	// Scan-side address
	fb_addr_t rd_addr;

	// New strobe only, the ack cycle itself is not a second write
	assign wr_hit = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;

	// Blanked coordinates read as 0, the word is fetched anyway
	assign rd_addr = fb_addr_t'(scan.y) * fb_addr_t'(h_active) + fb_addr_t'(scan.x);

	////////////////////
	// Handshake
	////////////////////

	// Ack one cycle after the strobe
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			wb_rsp.ack <= 1'b0;
		end else begin
			wb_rsp.ack <= wr_hit;
		end
	end

	////////////////////
	// Memory ports
	////////////////////

	// Simple dual port, read returns old data on a collision
	always_ff @(posedge M10k_pll) begin
		if (wr_hit && wb_req.we) begin
			mem[wb_req.adr] <= wb_req.dat;
		end
		pixel <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: hw/vga/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
	import video_timing_pkg::*;
(
	input  logic      M10k_pll,
	input  logic      reset,
	output scan_pos_t scan,
	output logic      hsync,
	output logic      vsync
);

	// Horizontal machine
	section_t h_state;
	coord_t   h_count;
	// Vertical machine
	section_t v_state;
	coord_t   v_count;
	// Last clock of the back porch, next clock starts a new line
	logic     line_done;

	// Last count of each horizontal section
	function automatic coord_t h_last(input section_t st);
		case (st)
			st_active: h_last = coord_t'(h_active - 1);
			st_front:  h_last = coord_t'(h_front - 1);
			st_pulse:  h_last = coord_t'(h_pulse - 1);
			default:   h_last = coord_t'(h_back - 1);
		endcase
	endfunction

	// Last line of each vertical section
	function automatic coord_t v_last(input section_t st);
		case (st)
			st_active: v_last = coord_t'(v_active - 1);
			st_front:  v_last = coord_t'(v_front - 1);
			st_pulse:  v_last = coord_t'(v_pulse - 1);
			default:   v_last = coord_t'(v_back - 1);
		endcase
	endfunction

	// Section order, same on both axes
	function automatic section_t next_section(input section_t st);
		case (st)
			st_active: next_section = st_front;
			st_front:  next_section = st_pulse;
			st_pulse:  next_section = st_back;
			default:   next_section = st_active;
		endcase
	endfunction

	assign line_done = (h_state == st_back) && (h_count == h_last(st_back));

	////////////////////
	// Horizontal
	////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_state <= st_active;
			h_count <= '0;
		end else if (h_count == h_last(h_state)) begin
			// Counter restarts in every section
			h_count <= '0;
			h_state <= next_section(h_state);
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	////////////////////
	// Vertical
	////////////////////

	// Steps only at end of line, in step with x going back to 0
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			v_state <= st_active;
			v_count <= '0;
		end else if (line_done) begin
			if (v_count == v_last(v_state)) begin
				v_count <= '0;
				v_state <= next_section(v_state);
			end else begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	// Outputs straight from state, aligned with the counters
	always_comb begin
		scan.x      = (h_state == st_active) ? h_count : '0;
		scan.y      = (v_state == st_active) ? v_count : '0;
		scan.active = (h_state == st_active) && (v_state == st_active);
	end

	// Syncs are active low
	assign hsync = (h_state != st_pulse);
	assign vsync = (v_state != st_pulse);

endmodule

`default_nettype wire

// File: hw/vga/vga_pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_out
	import video_timing_pkg::*;
(
	input  logic      M10k_pll,
	input  logic      reset,
	input  scan_pos_t scan,
	input  logic      hsync,
	input  logic      vsync,
	input  pixel_t    pixel,
	output vga_out_t  vga
);

	// Scan and syncs one cycle late, lined up with RAM data
	scan_pos_t scan_d;
	logic      hsync_d;
	logic      vsync_d;
	// Pixel lies on the outline
	logic      on_border;
	// Color after overlay
	pixel_t    color;

	////////////////////
	// Align with memory
	////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			scan_d  <= '0;
			hsync_d <= 1'b1;
			vsync_d <= 1'b1;
		end else begin
			scan_d  <= scan;
			hsync_d <= hsync;
			vsync_d <= vsync;
		end
	end

	// Outline overlay
	always_comb begin
		on_border = (scan_d.x == border_x0) || (scan_d.x == border_x1) ||
			(scan_d.y == border_y0) || (scan_d.y == border_y1);
		color = on_border ? color_white : pixel;
	end

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			vga <= '{hsync: 1'b1, vsync: 1'b1, default: '0};
		end else begin
			vga.hsync   <= hsync_d;
			vga.vsync   <= vsync_d;
			vga.blank_n <= scan_d.active;
			// 3-3-2 into the top of each channel, black in blanking
			if (scan_d.active) begin
				vga.red   <= {color[7:5], 5'd0};
				vga.green <= {color[4:2], 5'd0};
				vga.blue  <= {color[1:0], 6'd0};
			end else begin
				vga.red   <= '0;
				vga.green <= '0;
				vga.blue  <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/vga_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_frame_top
	import video_timing_pkg::*, fb_bus_pkg::*;
(
	input  logic     M10k_pll,
	input  logic     reset,
	output vga_out_t vga
);

	// Write side
	wb_req_t   wb_req;
	wb_rsp_t   wb_rsp;
	// Scan side
	scan_pos_t scan;
	logic      hsync;
	logic      vsync;
	pixel_t    pixel;

	// Pattern source
	checker_writer checker_writer_inst (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp)
	);

	frame_buffer frame_buffer_inst (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.scan     (scan),
		.pixel    (pixel)
	);

	// Display scan, two cycles to the pins
	vga_timing vga_timing_inst (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.scan     (scan),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	vga_pixel_out vga_pixel_out_inst (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.scan     (scan),
		.hsync    (hsync),
		.vsync    (vsync),
		.pixel    (pixel),
		.vga      (vga)
	);

endmodule

`default_nettype wire

// File: test/tb_vga_checks.svh
`ifndef TB_VGA_CHECKS_SVH
`define TB_VGA_CHECKS_SVH

////////////////////
// Compare tasks
////////////////////

// Pin word as readable text
function automatic string format_output(input vga_out_t v);
	return $sformatf("hsync=%b vsync=%b blank_n=%b rgb=%0d,%0d,%0d",
		v.hsync, v.vsync, v.blank_n, v.red, v.green, v.blue);
endfunction

// Whole pin word, colors included
task automatic check_pixel(
	input string    name,
	input vga_out_t expected,
	input vga_out_t actual
);
	if (actual !== expected) begin
		$display("[ERROR] %s: expected %s, actual %s", name,
			format_output(expected), format_output(actual));
		abort_run();
	end
endtask

// One sync or blank level
task automatic check_sync(
	input string name,
	input logic  expected,
	input logic  actual
);
	if (actual !== expected) begin
		$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		abort_run();
	end
endtask

// Pins while reset holds the pipeline
task automatic check_reset_state(
	input string    name,
	input vga_out_t actual
);
	vga_out_t expected;
	// Syncs idle high, blanked and black
	expected         = '0;
	expected.hsync   = 1'b1;
	expected.vsync   = 1'b1;
	if (actual !== expected) begin
		$display("[ERROR] %s: expected %s, actual %s", name,
			format_output(expected), format_output(actual));
		abort_run();
	end
endtask

`endif

// File: test/tb_vga_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_frame_top
	import video_timing_pkg::*, fb_bus_pkg::*;
();

	////////////////////
	// Run length
	////////////////////

	localparam int frame_cycles    = h_total * v_total;
	// One write every 2 cycles over the whole buffer
	localparam int fill_cycles     = 2 * fb_depth;
	localparam int frames_to_check = 3;
	localparam int timeout_cycles  = 4 * frame_cycles + 2 * fill_cycles;

	logic     M10k_pll = 1'b0;
	logic     reset;
	vga_out_t vga;

	// Reset level seen by the last two rising edges, newest in bit 0
	logic [1:0] rst_q = 2'b00;
	int         cycle_count = 0;
	// Model of the screen position now on the pins
	int         h_pos = 0;
	int         v_line = 0;
	int         since_reset = 0;
	// Frame started with the buffer fully written
	logic       frame_checked = 1'b0;
	int         frames_checked = 0;
	vga_out_t   model_out;
	string      where;
	// Second reset
	int         reset_at;
	int         reset_len;

	vga_frame_top vga_frame_top_inst (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.vga      (vga)
	);

	`include "tb_vga_checks.svh"

	// Fail message, then stop with a failing exit status
	task automatic abort_run;
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	// White rectangle lines
	function automatic logic on_outline(input int x, input int y);
		return (x == int'(border_x0)) || (x == int'(border_x1)) ||
			(y == int'(border_y0)) || (y == int'(border_y1));
	endfunction

	// Expected pins for one screen position
	function automatic vga_out_t expected_out(input int x, input int y);
		vga_out_t    e;
		logic [23:0] rgb;
		e.hsync   = !((x >= h_active + h_front) && (x < h_active + h_front + h_pulse));
		e.vsync   = !((y >= v_active + v_front) && (y < v_active + v_front + v_pulse));
		e.blank_n = (x < h_active) && (y < v_active);
		rgb = 24'd0;
		if (e.blank_n) begin
			if (on_outline(x, y)) begin
				rgb = {8'd224, 8'd224, 8'd192};
			end else if (x < h_active / 2) begin
				// Red over green on the left
				rgb = (y < v_active / 2) ? {8'd224, 8'd0, 8'd0} : {8'd0, 8'd224, 8'd0};
			end else begin
				// Blue over yellow on the right
				rgb = (y < v_active / 2) ? {8'd0, 8'd0, 8'd192} : {8'd224, 8'd224, 8'd0};
			end
		end
		{e.red, e.green, e.blue} = rgb;
		return e;
	endfunction

	always #10 M10k_pll = ~M10k_pll;

	// Reset history and timeout
	always @(posedge M10k_pll) begin
		rst_q       <= {rst_q[0], reset};
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles with %0d frames checked",
				cycle_count, frames_checked);
			abort_run();
		end
	end

	////////////////////
	// Output monitor
	////////////////////

	// Pins are stable at the falling edge
	always @(negedge M10k_pll) begin
		if (rst_q != 2'b00) begin
			// In reset and one cycle after it
			check_reset_state("reset state", vga);
			h_pos         = 0;
			v_line        = 0;
			since_reset   = 0;
			frame_checked = 1'b0;
		end else begin
			if (h_pos == 0 && v_line == 0) begin
				frame_checked = (since_reset >= fill_cycles);
			end
			model_out = expected_out(h_pos, v_line);
			where     = $sformatf("x=%0d y=%0d", h_pos, v_line);
			check_sync({"hsync ", where}, model_out.hsync, vga.hsync);
			check_sync({"vsync ", where}, model_out.vsync, vga.vsync);
			check_sync({"blank_n ", where}, model_out.blank_n, vga.blank_n);
			// Quadrant colors only once the buffer holds a full pass
			if (!model_out.blank_n || frame_checked || on_outline(h_pos, v_line)) begin
				check_pixel({"pixel ", where}, model_out, vga);
			end
			if (frame_checked && h_pos == h_active - 1 && v_line == v_active - 1) begin
				frames_checked++;
			end
			// Step the scan position
			if (h_pos == h_total - 1) begin
				h_pos  = 0;
				v_line = (v_line == v_total - 1) ? 0 : v_line + 1;
			end else begin
				h_pos++;
			end
			since_reset++;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		reset <= 1'b1;
		void'($urandom(32));
		reset_at  = $urandom_range(frame_cycles - 1, 1);
		reset_len = $urandom_range(20, 1);
		repeat (8) @(posedge M10k_pll);
		reset <= 1'b0;
		// Interrupt the first frame
		repeat (reset_at) @(posedge M10k_pll);
		$display("Second reset after %0d cycles, held for %0d cycles", reset_at, reset_len);
		reset <= 1'b1;
		repeat (reset_len) @(posedge M10k_pll);
		reset <= 1'b0;
		while (frames_checked < frames_to_check) begin
			@(posedge M10k_pll);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+test
common/video_timing_pkg.sv
common/fb_bus_pkg.sv
hw/checker_writer.sv
hw/frame_buffer/frame_buffer.sv
hw/vga/vga_timing.sv
hw/vga/vga_pixel_out.sv
hw/vga_frame_top.sv
test/tb_vga_frame_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_vga_frame_top
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run, exit status is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
